// File: vlog.f
+incdir+test
verilog/nnWeightsPkg.sv
verilog/nnTypesPkg.sv
verilog/sampleLatch.sv
verilog/neuronNode.sv
verilog/argmaxSelect.sv
verilog/denseLayer.sv
test/denseLayerTb.sv

// File: Bender.yml
package:
  name: dense_layer

sources:
  - verilog/nnWeightsPkg.sv
  - verilog/nnTypesPkg.sv
  - verilog/sampleLatch.sv
  - verilog/neuronNode.sv
  - verilog/argmaxSelect.sv
  - verilog/denseLayer.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/denseLayerTb.sv

// File: test/layerModel.svh
`ifndef LAYER_MODEL_SVH
`define LAYER_MODEL_SVH

// reference model of the layer, included inside the testbench module.
// the arithmetic is done in plain integers, straight from the layer rules.

// any sum at or above this value no longer fits the output scale.
localparam int SatLimit = (int'(nnTypesPkg::ActMax) + 1) << nnTypesPkg::FracShift;

function automatic nnTypesPkg::actOut modelActivation(input nnTypesPkg::inputVector s,
	input int node);
	int sum;
	int scaled;
	sum = int'(nnWeightsPkg::LayerBias[node]);
	for (int i = 0; i < nnWeightsPkg::NumInputs; i++)
	begin
		sum = sum + int'(s.act[i]) * int'(nnWeightsPkg::LayerWeights[node][i]);
	end
	if (sum < 0)
	begin
		return '0;
	end
	if (sum >= SatLimit)
	begin
		return nnTypesPkg::ActMax;
	end
	// round half up, then clamp a carry into 128.
	scaled = (sum + (1 << (nnTypesPkg::FracShift - 1))) >> nnTypesPkg::FracShift;
	if (scaled > int'(nnTypesPkg::ActMax))
	begin
		return nnTypesPkg::ActMax;
	end
	return nnTypesPkg::actOut'(scaled);
endfunction

function automatic nnTypesPkg::layerResult modelResult(input nnTypesPkg::inputVector s);
	nnTypesPkg::layerResult r;
	r = '0;
	for (int n = 0; n < nnWeightsPkg::NumNodes; n++)
	begin
		r.acts[n] = modelActivation(s, n);
	end
	// ties keep the lowest node index.
	r.winner = '0;
	r.peak = r.acts[0];
	for (int n = 1; n < nnWeightsPkg::NumNodes; n++)
	begin
		if (r.acts[n] > r.peak)
		begin
			r.winner = nnTypesPkg::classIdx'(n);
			r.peak = r.acts[n];
		end
	end
	return r;
endfunction

`endif

// File: test/denseLayerTb.sv
`timescale 1ns/1ps
`default_nettype none

module denseLayerTb;

	localparam int RandomSamples = 300;
	localparam int BurstSamples = 50;
	localparam int DrainTimeout = 64;

	// a result appears four negative edges after the edge that drove its strobe.
	localparam int ResultDelay = 4;

	logic clk;
	logic reset;
	logic inValid;
	nnTypesPkg::inputVector inSample;
	logic outValid;
	nnTypesPkg::layerResult result;

	integer seed;
	int edgeCount;
	int samplesSent;
	int resultsSeen;
	nnTypesPkg::layerResult expectQ [$];
	int dueQ [$];

	`include "layerModel.svh"

	denseLayer DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inSample(inSample),
		.outValid(outValid),
		.result(result)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		edgeCount <= edgeCount + 1;
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected)
		begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic sendSample(input nnTypesPkg::inputVector s);
		@(posedge clk);
		inValid <= 1'b1;
		inSample <= s;
		samplesSent++;
	endtask

	task automatic idleCycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			inValid <= 1'b0;
		end
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expectQ.size() > 0 && waited < DrainTimeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (expectQ.size() > 0)
		begin
			failRun("no result arrived for a pending sample before the timeout");
		end
	endtask

	function automatic nnTypesPkg::inputVector randomSample();
		nnTypesPkg::inputVector s;
		for (int i = 0; i < nnWeightsPkg::NumInputs; i++)
		begin
			s.act[i] = nnTypesPkg::actIn'($random(seed));
		end
		return s;
	endfunction

	// outputs and strobes are all stable at the falling edge.
	always @(negedge clk)
	begin
		nnTypesPkg::layerResult expected;
		if (!reset)
		begin
			if (outValid)
			begin
				if (expectQ.size() == 0)
				begin
					failRun("outValid rose while no sample was in flight");
				end
				else
				begin
					expected = expectQ.pop_front();
					checkValue("outValid cycle", edgeCount, dueQ.pop_front());
					checkValue("result.acts", result.acts, expected.acts);
					checkValue("result.winner", result.winner, expected.winner);
					checkValue("result.peak", result.peak, expected.peak);
					resultsSeen++;
				end
			end
			else if (dueQ.size() > 0 && dueQ[0] <= edgeCount)
			begin
				failRun("a result did not arrive on its expected cycle");
			end
			if (inValid)
			begin
				expectQ.push_back(modelResult(inSample));
				dueQ.push_back(edgeCount + ResultDelay);
			end
		end
	end

	initial
	begin
		nnTypesPkg::inputVector s;
		int gap;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		inSample = '0;
		seed = 32'h208ec007;
		edgeCount = 0;
		samplesSent = 0;
		resultsSeen = 0;

		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// the output side must stay quiet and cleared after reset.
		repeat (10)
		begin
			@(negedge clk);
			checkValue("outValid", outValid, 1'b0);
			checkValue("result", result, '0);
		end

		// full scale inputs drive the nodes into saturation and rectification.
		for (int i = 0; i < nnWeightsPkg::NumInputs; i++)
		begin
			s.act[i] = 8'sd127;
		end
		sendSample(s);
		for (int i = 0; i < nnWeightsPkg::NumInputs; i++)
		begin
			s.act[i] = -8'sd128;
		end
		sendSample(s);
		idleCycles(2);

		// one small input at a time keeps the sums near the rounding point.
		for (int i = 0; i < nnWeightsPkg::NumInputs; i++)
		begin
			s = '0;
			s.act[i] = (i % 2) ? nnTypesPkg::actIn'(-(i + 1)) : nnTypesPkg::actIn'(i + 1);
			sendSample(s);
			idleCycles(1);
		end

		sendSample('0);
		idleCycles(3);

		repeat (RandomSamples)
		begin
			sendSample(randomSample());
			gap = $unsigned($random(seed)) % 4;
			idleCycles(gap);
		end
		idleCycles(2);

		repeat (BurstSamples)
		begin
			sendSample(randomSample());
		end
		idleCycles(1);

		waitDrain();
		checkValue("result count", resultsSeen, samplesSent);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/denseLayer.sv
`timescale 1ns/1ps
`default_nettype none

module denseLayer (
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire nnTypesPkg::inputVector inSample,
	output logic outValid,
	output nnTypesPkg::layerResult result
);

	logic issuedValid;
	nnTypesPkg::inputVector issuedSample;
	nnTypesPkg::actOut [nnWeightsPkg::NumNodes-1:0] nodeActs;

	sampleLatch latch (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inSample(inSample),
		.issuedValid(issuedValid),
		.issuedSample(issuedSample)
	);

	// every node sees the same sample and picks its own weight row.
	for (genvar n = 0; n < nnWeightsPkg::NumNodes; n++)
	begin : nodes
		neuronNode #(
			.NodeIndex(n)
		) node (
			.clk(clk),
			.reset(reset),
			.sample(issuedSample),
			.act(nodeActs[n])
		);
	end

	argmaxSelect selector (
		.clk(clk),
		.reset(reset),
		.issuedValid(issuedValid),
		.nodeActs(nodeActs),
		.outValid(outValid),
		.result(result)
	);

endmodule

`default_nettype wire

// File: verilog/argmaxSelect.sv
`timescale 1ns/1ps
`default_nettype none

module argmaxSelect (
	input wire logic clk,
	input wire logic reset,
	input wire logic issuedValid,
	input wire nnTypesPkg::actOut [nnWeightsPkg::NumNodes-1:0] nodeActs,
	output logic outValid,
	output nnTypesPkg::layerResult result
);

	localparam int Stages = nnWeightsPkg::NodeLatency;

	logic [Stages-1:0] validPipe;
	logic alignedValid;
	nnTypesPkg::classIdx bestIdx;
	nnTypesPkg::actOut bestAct;

	// the strobe travels alongside the node pipeline.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[Stages-2:0], issuedValid};
		end
	end

	assign alignedValid = validPipe[Stages-1];

	// only a strictly larger value takes over, so ties keep the lower index.
	always_comb
	begin
		bestIdx = '0;
		bestAct = nodeActs[0];
		for (int n = 1; n < nnWeightsPkg::NumNodes; n++)
		begin
			if (nodeActs[n] > bestAct)
			begin
				bestIdx = nnTypesPkg::classIdx'(n);
				bestAct = nodeActs[n];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
			result <= '0;
		end
		else
		begin
			outValid <= alignedValid;
			if (alignedValid)
			begin
				result.acts <= nodeActs;
				result.winner <= bestIdx;
				result.peak <= bestAct;
			end
		end
	end

	outValidKnown: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(outValid)
	);

endmodule

`default_nettype wire

// File: verilog/neuronNode.sv
`timescale 1ns/1ps
`default_nettype none

module neuronNode #(
	parameter int NodeIndex = 0
) (
	input wire logic clk,
	input wire logic reset,
	input wire nnTypesPkg::inputVector sample,
	output nnTypesPkg::actOut act
);

	localparam int ActBits = $bits(nnTypesPkg::actOut);
	localparam int AccBits = $bits(nnTypesPkg::accumT);

	// lowest bit that must be clear for the sum to fit the output range.
	localparam int UpperLsb = nnTypesPkg::FracShift + ActBits - 1;

	nnTypesPkg::productT products [nnWeightsPkg::NumInputs];
	nnTypesPkg::accumT sumNext;
	nnTypesPkg::accumT sum;

	// negative sums are rectified to zero, large ones saturate, and the
	// rest are rounded half up on the dropped fraction bits.
	function automatic nnTypesPkg::actOut requantize(input nnTypesPkg::accumT value);
		logic [ActBits:0] rounded;
		rounded = value[nnTypesPkg::FracShift +: ActBits]
			+ value[nnTypesPkg::FracShift-1];
		if (value[AccBits-1])
		begin
			return '0;
		end
		if (value[AccBits-2:UpperLsb] != '0)
		begin
			return nnTypesPkg::ActMax;
		end
		// a carry out of the rounding can still reach 128.
		if (rounded > nnTypesPkg::ActMax)
		begin
			return nnTypesPkg::ActMax;
		end
		return rounded[ActBits-1:0];
	endfunction

	always_comb
	begin
		for (int i = 0; i < nnWeightsPkg::NumInputs; i++)
		begin
			products[i] = nnTypesPkg::productT'($signed(sample.act[i]))
				* nnTypesPkg::productT'(nnWeightsPkg::LayerWeights[NodeIndex][i]);
		end
	end

	always_comb
	begin
		sumNext = nnTypesPkg::accumT'(nnWeightsPkg::LayerBias[NodeIndex]);
		for (int i = 0; i < nnWeightsPkg::NumInputs; i++)
		begin
			sumNext = sumNext + nnTypesPkg::accumT'(products[i]);
		end
	end

	// the sum and the activation each take one edge.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sum <= '0;
			act <= '0;
		end
		else
		begin
			sum <= sumNext;
			act <= requantize(sum);
		end
	end

	actInRange: assert property (
		@(posedge clk) disable iff (reset)
		act <= nnTypesPkg::ActMax
	);

endmodule

`default_nettype wire

// File: verilog/sampleLatch.sv
`timescale 1ns/1ps
`default_nettype none

module sampleLatch (
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire nnTypesPkg::inputVector inSample,
	output logic issuedValid,
	output nnTypesPkg::inputVector issuedSample
);

	// the sample is only loaded on a strobe, so the nodes see stable
	// operands while the input side is idle.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issuedValid <= 1'b0;
			issuedSample <= '0;
		end
		else
		begin
			issuedValid <= inValid;
			if (inValid)
			begin
				issuedSample <= inSample;
			end
		end
	end

	// every issue strobe must come from a strobe one cycle earlier.
	issueFollowsInput: assert property (
		@(posedge clk) disable iff (reset)
		issuedValid |-> $past(inValid)
	);

endmodule

`default_nettype wire

// File: verilog/nnTypesPkg.sv
`default_nettype none

package nnTypesPkg;

	// one input activation and one weight, both signed bytes.
	typedef logic signed [7:0] actIn;
	typedef logic signed [7:0] weightT;

	// the product of an activation and a weight always fits in 16 bits.
	typedef logic signed [15:0] productT;

	// thirty products plus the bias need no more than 23 bits.
	typedef logic signed [22:0] accumT;

	// a node activation after rectification, 0 to ActMax.
	typedef logic [7:0] actOut;

	typedef logic [$clog2(nnWeightsPkg::NumNodes)-1:0] classIdx;

	// fraction bits dropped when the sum is brought back to activation scale.
	localparam int FracShift = 6;
	localparam actOut ActMax = 8'd127;

	typedef struct packed {
		actIn [nnWeightsPkg::NumInputs-1:0] act;
	} inputVector;

	typedef struct packed {
		actOut [nnWeightsPkg::NumNodes-1:0] acts;
		classIdx winner;
		actOut peak;
	} layerResult;

endpackage

`default_nettype wire

// File: verilog/nnWeightsPkg.sv
`default_nettype none

package nnWeightsPkg;

	localparam int NumInputs = 30;
	localparam int NumNodes = 8;

	// one edge for the sum register and one for the activation register.
	localparam int NodeLatency = 2;

	// row n holds the weights of node n, column i multiplies input i.
	localparam logic signed [7:0] LayerWeights [NumNodes][NumInputs] = '{
		'{  3, -17,  25,   8,  -4,  30, -12,   1,  19, -27,   6,  14,  -9,  22,  -1,
		   11, -30,   5,  17,  -6,  28, -15,   2,   9, -21,  13,  -3,  26,  -8,   4},
		'{-22,   7,  16, -11,  29,   0,  -5,  18, -26,  10,   3, -14,  21,  -2,  27,
		   -7,  12, -19,  24,   1, -31,   8,  15, -10,  20,  -4,   6, -23,  31, -13},
		'{ 14,   2,  -8,  27, -16,   9,  23,  -3,   5, -29,  18,  11,  -6,   0,  20,
		  -25,   4,  13,  -1,  30,  -9,  16, -18,   7,  22, -12,  26,   3, -15,  10},
		'{ -5,  24,  11, -20,   6, -13,  31,  15,  -7,   2, -28,  19,   8, -17,  12,
		   25,  -3, -10,  21,   5,  14, -24,   0,  28,  -6,   9, -19,  17,   1, -11},
		'{ 19,  -9,  -2,  13,  26, -21,   4, -14,  30,   7,  -1, -25,  16,  10, -30,
		    3,  22,   8, -12, -18,  11,  29,  -5, -16,   2,  24,  -8, -27,  15,   6},
		'{  0,  12, -24,   5, -10,  17, -29,  21,   2,  14,  25,  -7, -18,  31,   8,
		  -13,   1,  27,  -4,   9, -20,   3,  18, -26,  11,  -2,  23,   6,  -9, -17},
		'{-28,  15,   6,  -3,  20,  10, -11,  27, -18,   4,  13,   1,  29, -22,  -6,
		   18,   9, -14,   2, -27,   7,  21,  -1,  12,  -8,  30, -16,   5,  24, -19},
		'{  8, -26,  18,  23,  -7,  -2,  14, -19,  11,  28, -12,   5, -31,   3,  16,
		   -4,  26, -22,  10,  12, -15,  -6,  31,   4, -24,  19,   7, -11, -20,   9}
	};

	// biases are on the same scale as the products, so 64 is one output step.
	localparam logic signed [15:0] LayerBias [NumNodes] = '{
		0,
		96,
		-48,
		160,
		-200,
		32,
		64,
		-16
	};

endpackage

`default_nettype wire
